// File: include/mmio_regs.svh
`ifndef MMIO_REGS_SVH
`define MMIO_REGS_SVH

// Register window size in 32-bit words
localparam int MMIO_WORDS = 16;

// Word indexes, byte offset is index * 4
localparam mmio_idx_t REG_CMD           = 4'd0;
localparam mmio_idx_t REG_CAM0_CMD      = 4'd1;
localparam mmio_idx_t REG_CAM1_CMD      = 4'd2;
localparam mmio_idx_t REG_FRAME_BYTES0  = 4'd3;
localparam mmio_idx_t REG_TRIBUF_ADDR0  = 4'd4;
localparam mmio_idx_t REG_FRAME_BYTES1  = 4'd5;
localparam mmio_idx_t REG_TRIBUF_ADDR1  = 4'd6;
localparam mmio_idx_t REG_FRAME_BYTES2  = 4'd7;
localparam mmio_idx_t REG_TRIBUF_ADDR2  = 4'd8;

// Read-only camera response view
localparam mmio_idx_t REG_CAM0_RESP     = 4'd9;
localparam mmio_idx_t REG_CAM0_RESP_CNT = 4'd10;
localparam mmio_idx_t REG_CAM1_RESP     = 4'd11;
localparam mmio_idx_t REG_CAM1_RESP_CNT = 4'd12;
localparam mmio_idx_t REG_CAM_STATUS    = 4'd13;
localparam mmio_idx_t REG_IRQ_EN        = 4'd14;
localparam mmio_idx_t REG_IRQ_STAT      = 4'd15;

`endif

// File: hw/mmio_pkg.sv
package mmio_pkg;

    // Bus data word and byte address
    typedef logic [31:0] mmio_word_t;
    typedef logic [31:0] mmio_addr_t;

    // Word index into the register window
    typedef logic [3:0] mmio_idx_t;

    // One strobe bit per byte lane
    typedef logic [3:0] mmio_strb_t;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    `include "mmio_regs.svh"

endpackage

// File: hw/cam_pkg.sv
package cam_pkg;

    // Command word sent to a camera controller
    typedef logic [31:0] cam_cmd_t;

    // Response word returned by a camera controller
    typedef logic [17:0] cam_resp_t;

    // Free credits per port
    typedef logic [3:0] cam_credit_t;

    // Number of commands waiting in a port queue
    typedef logic [2:0] cam_fill_t;

    // Packed per-port status, overflow / fill / credits
    typedef logic [7:0] cam_status_t;

    // Wraps at 2^16
    typedef logic [15:0] cam_cnt_t;

endpackage

// File: hw/mmio_bus_if.sv
`timescale 1ns/1ns

interface mmio_bus_if import mmio_pkg::*; ();

    // Write side, one-cycle strobe per committed write
    logic       wr_en;
    mmio_idx_t  wr_idx;
    mmio_word_t wr_data;
    mmio_strb_t wr_strb;

    // Read side, data follows rd_idx in the same cycle
    mmio_idx_t  rd_idx;
    mmio_word_t rd_data;

    modport ctrl (
        output wr_en,
        output wr_idx,
        output wr_data,
        output wr_strb,
        output rd_idx,
        input  rd_data
    );

    modport regs (
        input  wr_en,
        input  wr_idx,
        input  wr_data,
        input  wr_strb,
        input  rd_idx,
        output rd_data
    );

endinterface

// File: hw/mmio_ctrl.sv
`timescale 1ns/1ns

module mmio_ctrl import mmio_pkg::*; #(
    parameter mmio_addr_t MMIO_BASE = 32'h7000_0000
) (
    input  logic       fclk,
    input  logic       rst_n,

    input  mmio_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    output mmio_word_t rdata,
    output axi_resp_t  rresp,
    output logic       rvalid,
    input  logic       rready,

    input  mmio_addr_t awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  mmio_word_t wdata,
    input  mmio_strb_t wstrb,
    input  logic       wvalid,
    output logic       wready,
    output axi_resp_t  bresp,
    output logic       bvalid,
    input  logic       bready,

    mmio_bus_if.ctrl   bus
);

    typedef enum logic {
        R_IDLE,
        R_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,
        W_RESP
    } wr_state_t;

    // Top address bit that selects a word inside the window
    localparam int WIN_MSB = $clog2(MMIO_WORDS) + 1;

    rd_state_t  r_state;
    wr_state_t  w_state;
    logic       ar_good;
    logic       aw_good;
    mmio_idx_t  wr_idx_q;
    logic       wr_good_q;

    // Inside the window and word aligned
    function automatic logic addr_ok(input mmio_addr_t addr);
        return (addr[31:WIN_MSB+1] == MMIO_BASE[31:WIN_MSB+1]) && (addr[1:0] == 2'b00);
    endfunction

    assign ar_good = addr_ok(araddr);
    assign aw_good = addr_ok(awaddr);

    // Read channel
    assign arready    = (r_state == R_IDLE);
    assign rvalid     = (r_state == R_DATA);
    assign bus.rd_idx = araddr[WIN_MSB:2];

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            r_state <= R_IDLE;
        end else begin
            case (r_state)
                R_IDLE: if (arvalid) r_state <= R_DATA;
                R_DATA: if (rready) r_state <= R_IDLE;
                default: r_state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge fclk) begin
        if (arready && arvalid) begin
            rdata <= ar_good ? bus.rd_data : '0;
            rresp <= ar_good ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Write channel
    assign awready = (w_state == W_IDLE);
    assign wready  = (w_state == W_DATA);
    assign bvalid  = (w_state == W_RESP);

    // Bad addresses still complete the handshake but never reach the registers
    assign bus.wr_en   = wready && wvalid && wr_good_q;
    assign bus.wr_idx  = wr_idx_q;
    assign bus.wr_data = wdata;
    assign bus.wr_strb = wstrb;

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            w_state   <= W_IDLE;
            wr_good_q <= 1'b0;
        end else begin
            case (w_state)
                W_IDLE: begin
                    if (awvalid) begin
                        wr_good_q <= aw_good;
                        w_state   <= W_DATA;
                    end
                end
                W_DATA: if (wvalid) w_state <= W_RESP;
                W_RESP: if (bready) w_state <= W_IDLE;
                default: w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge fclk) begin
        if (awready && awvalid) begin
            wr_idx_q <= awaddr[WIN_MSB:2];
            bresp    <= aw_good ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// File: hw/mmio_regfile.sv
`timescale 1ns/1ns

module mmio_regfile import mmio_pkg::*, cam_pkg::*; (
    input  logic        fclk,
    input  logic        rst_n,

    input  cam_status_t status0,
    input  cam_status_t status1,
    input  cam_resp_t   resp0,
    input  cam_resp_t   resp1,
    input  cam_cnt_t    cnt0,
    input  cam_cnt_t    cnt1,
    input  logic        resp_event0,
    input  logic        resp_event1,

    output mmio_word_t  frame_bytes0,
    output mmio_word_t  frame_bytes1,
    output mmio_word_t  frame_bytes2,
    output mmio_word_t  tribuf_addr0,
    output mmio_word_t  tribuf_addr1,
    output mmio_word_t  tribuf_addr2,
    output mmio_word_t  mmio_cmd,
    output logic        mmio_cmd_valid,
    output logic        push0,
    output logic        push1,
    output cam_cmd_t    push_cmd,
    output logic        irq,

    mmio_bus_if.regs    bus
);

    // Frame config words sit at REG_FRAME_BYTES0 onwards
    localparam int CFG_WORDS = 6;

    mmio_word_t cfg [CFG_WORDS];
    logic [1:0] irq_en;
    logic [1:0] irq_stat;
    logic [1:0] stat_clr;

    function automatic mmio_word_t merge(input mmio_word_t old_w, input mmio_word_t new_w,
                                         input mmio_strb_t strb);
        mmio_word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    assign stat_clr = (bus.wr_en && bus.wr_idx == REG_IRQ_STAT && bus.wr_strb[0]) ?
                      bus.wr_data[1:0] : 2'b00;

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            cfg            <= '{default: '0};
            irq_en         <= '0;
            irq_stat       <= '0;
            mmio_cmd_valid <= 1'b0;
            push0          <= 1'b0;
            push1          <= 1'b0;
        end else begin
            mmio_cmd_valid <= bus.wr_en && (bus.wr_idx == REG_CMD);
            push0          <= bus.wr_en && (bus.wr_idx == REG_CAM0_CMD);
            push1          <= bus.wr_en && (bus.wr_idx == REG_CAM1_CMD);
            if (bus.wr_en) begin
                for (int i = 0; i < CFG_WORDS; i++) begin
                    if (bus.wr_idx == mmio_idx_t'(REG_FRAME_BYTES0 + i))
                        cfg[i] <= merge(cfg[i], bus.wr_data, bus.wr_strb);
                end
                if (bus.wr_idx == REG_IRQ_EN && bus.wr_strb[0]) irq_en <= bus.wr_data[1:0];
            end
            // A new event wins over a clear in the same cycle
            irq_stat <= (irq_stat & ~stat_clr) | {resp_event1, resp_event0};
        end
    end

    always_ff @(posedge fclk) begin
        if (bus.wr_en && bus.wr_idx == REG_CMD) mmio_cmd <= bus.wr_data;
        if (bus.wr_en && (bus.wr_idx == REG_CAM0_CMD || bus.wr_idx == REG_CAM1_CMD))
            push_cmd <= bus.wr_data;
    end

    assign frame_bytes0 = cfg[0];
    assign tribuf_addr0 = cfg[1];
    assign frame_bytes1 = cfg[2];
    assign tribuf_addr1 = cfg[3];
    assign frame_bytes2 = cfg[4];
    assign tribuf_addr2 = cfg[5];

    assign irq = |(irq_stat & irq_en);

    // Readback, command words read as 0
    always_comb begin
        case (bus.rd_idx)
            REG_FRAME_BYTES0:  bus.rd_data = cfg[0];
            REG_TRIBUF_ADDR0:  bus.rd_data = cfg[1];
            REG_FRAME_BYTES1:  bus.rd_data = cfg[2];
            REG_TRIBUF_ADDR1:  bus.rd_data = cfg[3];
            REG_FRAME_BYTES2:  bus.rd_data = cfg[4];
            REG_TRIBUF_ADDR2:  bus.rd_data = cfg[5];
            REG_CAM0_RESP:     bus.rd_data = {14'd0, resp0};
            REG_CAM0_RESP_CNT: bus.rd_data = {16'd0, cnt0};
            REG_CAM1_RESP:     bus.rd_data = {14'd0, resp1};
            REG_CAM1_RESP_CNT: bus.rd_data = {16'd0, cnt1};
            REG_CAM_STATUS:    bus.rd_data = {16'd0, status1, status0};
            REG_IRQ_EN:        bus.rd_data = {30'd0, irq_en};
            REG_IRQ_STAT:      bus.rd_data = {30'd0, irq_stat};
            default:           bus.rd_data = '0;
        endcase
    end

endmodule

// File: hw/cam_cmd_port.sv
`timescale 1ns/1ns

module cam_cmd_port import cam_pkg::*; #(
    parameter int CAM_CREDITS = 2,
    parameter int CMD_DEPTH   = 4
) (
    input  logic        fclk,
    input  logic        rst_n,

    input  logic        push,
    input  cam_cmd_t    push_cmd,
    input  cam_resp_t   cam_resp,
    input  logic        cam_resp_valid,

    output cam_cmd_t    cam_cmd,
    output logic        cam_cmd_valid,
    output cam_status_t status,
    output cam_resp_t   last_resp,
    output cam_cnt_t    resp_cnt,
    output logic        resp_event
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;

    cam_cmd_t    queue [CMD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    cam_fill_t   fill;
    cam_credit_t credits;
    logic        overflow;
    logic        full;
    logic        accept;
    logic        send;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full   = (fill == cam_fill_t'(CMD_DEPTH));
    assign accept = push && !full;

    // Head goes out whenever a credit is free
    assign send          = (fill != '0) && (credits != '0);
    assign cam_cmd_valid = send;
    assign cam_cmd       = queue[rd_ptr];

    always_ff @(posedge fclk) begin
        if (accept) queue[wr_ptr] <= push_cmd;
    end

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            credits  <= cam_credit_t'(CAM_CREDITS);
            overflow <= 1'b0;
        end else begin
            if (accept) wr_ptr <= ptr_inc(wr_ptr);
            if (send) rd_ptr <= ptr_inc(rd_ptr);
            fill    <= fill + cam_fill_t'(accept) - cam_fill_t'(send);
            // Each response hands one credit back
            credits <= credits + cam_credit_t'(cam_resp_valid) - cam_credit_t'(send);
            if (push && full) overflow <= 1'b1;
        end
    end

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            last_resp <= '0;
            resp_cnt  <= '0;
        end else if (cam_resp_valid) begin
            last_resp <= cam_resp;
            resp_cnt  <= resp_cnt + 1'b1;
        end
    end

    // Lands in the IRQ status register together with last_resp
    assign resp_event = cam_resp_valid;

    assign status = {overflow, fill, credits};

endmodule

// File: hw/mmio_top.sv
`timescale 1ns/1ns

module mmio_top import mmio_pkg::*, cam_pkg::*; #(
    parameter mmio_addr_t MMIO_BASE   = 32'h7000_0000,
    parameter int         CAM_CREDITS = 2,
    parameter int         CMD_DEPTH   = 4
) (
    input  logic       fclk,
    input  logic       rst_n,

    input  mmio_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    output mmio_word_t rdata,
    output axi_resp_t  rresp,
    output logic       rvalid,
    input  logic       rready,
    input  mmio_addr_t awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  mmio_word_t wdata,
    input  mmio_strb_t wstrb,
    input  logic       wvalid,
    output logic       wready,
    output axi_resp_t  bresp,
    output logic       bvalid,
    input  logic       bready,

    output mmio_word_t frame_bytes0,
    output mmio_word_t frame_bytes1,
    output mmio_word_t frame_bytes2,
    output mmio_word_t tribuf_addr0,
    output mmio_word_t tribuf_addr1,
    output mmio_word_t tribuf_addr2,
    output mmio_word_t mmio_cmd,
    output logic       mmio_cmd_valid,

    output cam_cmd_t   cam0_cmd,
    output logic       cam0_cmd_valid,
    input  cam_resp_t  cam0_resp,
    input  logic       cam0_resp_valid,
    output cam_cmd_t   cam1_cmd,
    output logic       cam1_cmd_valid,
    input  cam_resp_t  cam1_resp,
    input  logic       cam1_resp_valid,

    output logic       irq
);

    mmio_bus_if bus ();

    cam_status_t status0, status1;
    cam_resp_t   resp0, resp1;
    cam_cnt_t    cnt0, cnt1;
    logic        resp_event0, resp_event1;
    logic        push0, push1;
    cam_cmd_t    push_cmd;

    mmio_ctrl #(.MMIO_BASE(MMIO_BASE)) u_ctrl (
        .fclk, .rst_n,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .bus(bus.ctrl)
    );

    mmio_regfile u_regs (
        .fclk, .rst_n,
        .status0, .status1, .resp0, .resp1, .cnt0, .cnt1,
        .resp_event0, .resp_event1,
        .frame_bytes0, .frame_bytes1, .frame_bytes2,
        .tribuf_addr0, .tribuf_addr1, .tribuf_addr2,
        .mmio_cmd, .mmio_cmd_valid, .push0, .push1, .push_cmd, .irq,
        .bus(bus.regs)
    );

    cam_cmd_port #(.CAM_CREDITS(CAM_CREDITS), .CMD_DEPTH(CMD_DEPTH)) u_cam0 (
        .fclk, .rst_n,
        .push(push0), .push_cmd,
        .cam_resp(cam0_resp), .cam_resp_valid(cam0_resp_valid),
        .cam_cmd(cam0_cmd), .cam_cmd_valid(cam0_cmd_valid),
        .status(status0), .last_resp(resp0), .resp_cnt(cnt0), .resp_event(resp_event0)
    );

    cam_cmd_port #(.CAM_CREDITS(CAM_CREDITS), .CMD_DEPTH(CMD_DEPTH)) u_cam1 (
        .fclk, .rst_n,
        .push(push1), .push_cmd,
        .cam_resp(cam1_resp), .cam_resp_valid(cam1_resp_valid),
        .cam_cmd(cam1_cmd), .cam_cmd_valid(cam1_cmd_valid),
        .status(status1), .last_resp(resp1), .resp_cnt(cnt1), .resp_event(resp_event1)
    );

endmodule

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic fclk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        fclk = 1'b0;
        forever #4 fclk = ~fclk;
    end

    // Held low for the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge fclk);
        rst_n <= 1'b1;
    end

endmodule

// File: testbench/mmio_asserts.sv
`timescale 1ns/1ns

module mmio_asserts import cam_pkg::*; #(
    parameter int MAX_CREDITS = 2
) (
    input logic        fclk,
    input logic        rst_n,
    input logic        rvalid,
    input logic        rready,
    input logic        bvalid,
    input logic        bready,
    input logic        cmd_valid,
    input logic        resp_valid,
    input cam_credit_t credits
);

    // Commands sent but not yet answered
    cam_credit_t outstanding;

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + cam_credit_t'(cmd_valid) - cam_credit_t'(resp_valid);
        end
    end

    // Responses stay up until taken
    rvalid_hold: assert property (@(posedge fclk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    bvalid_hold: assert property (@(posedge fclk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    cmd_needs_credit: assert property (@(posedge fclk) disable iff (!rst_n)
        cmd_valid |-> outstanding < cam_credit_t'(MAX_CREDITS))
        else $error("camera command sent with no credit");

    credit_limit: assert property (@(posedge fclk) disable iff (!rst_n)
        credits <= cam_credit_t'(MAX_CREDITS))
        else $error("credit count above initial credits");

endmodule

bind mmio_ctrl mmio_asserts u_bus_asserts (
    .fclk(fclk), .rst_n(rst_n),
    .rvalid(rvalid), .rready(rready), .bvalid(bvalid), .bready(bready),
    .cmd_valid(1'b0), .resp_valid(1'b0), .credits(4'd0)
);

bind cam_cmd_port mmio_asserts #(.MAX_CREDITS(CAM_CREDITS)) u_credit_asserts (
    .fclk(fclk), .rst_n(rst_n),
    .rvalid(1'b0), .rready(1'b0), .bvalid(1'b0), .bready(1'b0),
    .cmd_valid(cam_cmd_valid), .resp_valid(cam_resp_valid), .credits(credits)
);

// File: testbench/tb_mmio.sv
`timescale 1ns/1ns

module tb_mmio import mmio_pkg::*, cam_pkg::*; ();

    localparam mmio_addr_t BASE    = 32'h7000_0000;
    localparam int         CREDITS = 2;
    localparam int         DEPTH   = 4;
    localparam int         TIMEOUT = 64;

    logic       fclk;
    logic       rst_n;
    mmio_addr_t araddr, awaddr;
    logic       arvalid, arready, rvalid, rready;
    logic       awvalid, awready, wvalid, wready, bvalid, bready;
    mmio_word_t rdata, wdata;
    axi_resp_t  rresp, bresp;
    mmio_strb_t wstrb;
    mmio_word_t frame_bytes0, frame_bytes1, frame_bytes2;
    mmio_word_t tribuf_addr0, tribuf_addr1, tribuf_addr2;
    mmio_word_t mmio_cmd;
    logic       mmio_cmd_valid;
    cam_cmd_t   cam0_cmd, cam1_cmd;
    logic       cam0_cmd_valid, cam1_cmd_valid;
    cam_resp_t  cam0_resp, cam1_resp;
    logic       cam0_resp_valid, cam1_resp_valid;
    logic       irq;

    integer     seed = 18689;
    cam_cmd_t   sent0[$];
    cam_cmd_t   sent1[$];
    int         cmd_pulses;
    mmio_word_t last_cmd;
    mmio_word_t cfg_exp [6];
    int         resp_total [2];

    tb_clk_gen u_clk (.fclk(fclk), .rst_n(rst_n));

    mmio_top #(.MMIO_BASE(BASE), .CAM_CREDITS(CREDITS), .CMD_DEPTH(DEPTH)) uut (.*);

    // Camera models, sampled mid-cycle
    always @(negedge fclk) begin
        if (rst_n && cam0_cmd_valid) sent0.push_back(cam0_cmd);
    end

    always @(negedge fclk) begin
        if (rst_n && cam1_cmd_valid) sent1.push_back(cam1_cmd);
    end

    always @(negedge fclk) begin
        if (rst_n && mmio_cmd_valid) begin
            cmd_pulses++;
            last_cmd = mmio_cmd;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input mmio_word_t exp, input mmio_word_t act);
        if (act !== exp)
            stop_run($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp)
            stop_run($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_cmd(input string name, input cam_cmd_t exp, input cam_cmd_t act);
        if (act !== exp)
            stop_run($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, act));
    endtask

    // All stimulus changes 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge fclk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    function automatic mmio_addr_t reg_addr(input mmio_idx_t idx);
        return BASE + mmio_addr_t'({idx, 2'b00});
    endfunction

    function automatic mmio_word_t cfg_output(input int i);
        case (i)
            0: return frame_bytes0;
            1: return tribuf_addr0;
            2: return frame_bytes1;
            3: return tribuf_addr1;
            4: return frame_bytes2;
            default: return tribuf_addr2;
        endcase
    endfunction

    task automatic axi_write(input mmio_addr_t addr, input mmio_word_t data,
                             input mmio_strb_t strb, output axi_resp_t resp);
        int n;
        idle_cycles($unsigned($random(seed)) % 3);
        awaddr  = addr;
        awvalid = 1'b1;
        n = 0;
        while (!awready) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for awready");
        end
        next_cycle();
        awvalid = 1'b0;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        n = 0;
        while (!wready) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for wready");
        end
        next_cycle();
        wvalid = 1'b0;
        // Response sits unclaimed for a while
        idle_cycles($unsigned($random(seed)) % 3);
        n = 0;
        while (!bvalid) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for bvalid");
        end
        resp   = bresp;
        bready = 1'b1;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input mmio_addr_t addr, output mmio_word_t data,
                            output axi_resp_t resp);
        int n;
        idle_cycles($unsigned($random(seed)) % 3);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for arready");
        end
        next_cycle();
        arvalid = 1'b0;
        idle_cycles($unsigned($random(seed)) % 3);
        n = 0;
        while (!rvalid) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for rvalid");
        end
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic reg_write(input mmio_idx_t idx, input mmio_word_t data,
                             input mmio_strb_t strb);
        axi_resp_t resp;
        axi_write(reg_addr(idx), data, strb, resp);
        check_resp($sformatf("bresp idx %0d", idx), RESP_OKAY, resp);
    endtask

    task automatic read_check(input mmio_idx_t idx, input mmio_word_t exp);
        axi_resp_t  resp;
        mmio_word_t data;
        axi_read(reg_addr(idx), data, resp);
        check_resp($sformatf("rresp idx %0d", idx), RESP_OKAY, resp);
        check_word($sformatf("rdata idx %0d", idx), exp, data);
    endtask

    task automatic wait_sent(input int cam, input int count);
        int n;
        n = 0;
        while (((cam == 0) ? sent0.size() : sent1.size()) < count) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) stop_run($sformatf("camera %0d never got command %0d", cam, count));
        end
    endtask

    task automatic send_resp(input int cam, input cam_resp_t r);
        if (cam == 0) begin
            cam0_resp       = r;
            cam0_resp_valid = 1'b1;
        end else begin
            cam1_resp       = r;
            cam1_resp_valid = 1'b1;
        end
        next_cycle();
        cam0_resp_valid = 1'b0;
        cam1_resp_valid = 1'b0;
        resp_total[cam]++;
    endtask

    task automatic config_regs();
        mmio_word_t d;
        mmio_idx_t  idx;
        for (int i = 0; i < 6; i++) begin
            idx = mmio_idx_t'(REG_FRAME_BYTES0 + i);
            d = $random(seed);
            reg_write(idx, d, 4'hF);
            // Lanes 0 and 2 only
            reg_write(idx, 32'hFFFF_FFFF, 4'b0101);
            d = (d & 32'hFF00_FF00) | 32'h00FF_00FF;
            reg_write(idx, 32'h0000_0000, 4'b1000);
            d = d & 32'h00FF_FFFF;
            cfg_exp[i] = d;
            read_check(idx, d);
            check_word($sformatf("config output %0d", i), d, cfg_output(i));
        end
    endtask

    task automatic bad_addresses();
        axi_resp_t  resp;
        mmio_word_t d;
        // One window up, lands on the FRAME_BYTES0 slot
        axi_write(BASE + 32'h4C, 32'hDEAD_BEEF, 4'hF, resp);
        check_resp("bresp out of window", RESP_SLVERR, resp);
        axi_write(BASE + 32'h12, 32'hDEAD_BEEF, 4'hF, resp);
        check_resp("bresp unaligned", RESP_SLVERR, resp);
        axi_read(BASE + 32'h4C, d, resp);
        check_resp("rresp out of window", RESP_SLVERR, resp);
        check_word("rdata out of window", 32'h0, d);
        axi_read(BASE - 32'h4, d, resp);
        check_resp("rresp below base", RESP_SLVERR, resp);
        check_word("rdata below base", 32'h0, d);
        axi_read(BASE + 32'h0D, d, resp);
        check_resp("rresp unaligned", RESP_SLVERR, resp);
        check_word("rdata unaligned", 32'h0, d);
        read_check(REG_FRAME_BYTES0, cfg_exp[0]);
        read_check(REG_TRIBUF_ADDR0, cfg_exp[1]);
    endtask

    task automatic command_pulse();
        cmd_pulses = 0;
        reg_write(REG_CMD, 32'hC0DE_0001, 4'hF);
        // Extra pulses would show up here
        idle_cycles(4);
        check_word("mmio_cmd_valid pulses", 32'd1, cmd_pulses);
        check_word("mmio_cmd", 32'hC0DE_0001, last_cmd);
        read_check(REG_CMD, 32'h0);
    endtask

    task automatic credit_flow();
        cam_resp_t r0, r1;
        for (int k = 0; k < 4; k++) begin
            reg_write(REG_CAM0_CMD, 32'hCA00_0000 + k, 4'hF);
            reg_write(REG_CAM1_CMD, 32'hCB00_0000 + k, 4'hF);
        end
        wait_sent(0, CREDITS);
        wait_sent(1, CREDITS);
        idle_cycles(4);
        check_word("cam0 commands before responses", CREDITS, sent0.size());
        check_word("cam1 commands before responses", CREDITS, sent1.size());
        for (int k = 0; k < 4; k++) begin
            r0 = cam_resp_t'(32'h2A000 + k);
            r1 = cam_resp_t'(32'h15550 + k);
            send_resp(0, r0);
            send_resp(1, r1);
            if (k < 2) begin
                wait_sent(0, CREDITS + 1 + k);
                wait_sent(1, CREDITS + 1 + k);
            end
        end
        idle_cycles(4);
        check_word("cam0 commands sent", 32'd4, sent0.size());
        check_word("cam1 commands sent", 32'd4, sent1.size());
        for (int k = 0; k < 4; k++) begin
            check_cmd($sformatf("cam0_cmd %0d", k), 32'hCA00_0000 + k, sent0[k]);
            check_cmd($sformatf("cam1_cmd %0d", k), 32'hCB00_0000 + k, sent1[k]);
        end
        read_check(REG_CAM0_RESP, mmio_word_t'(r0));
        read_check(REG_CAM0_RESP_CNT, resp_total[0]);
        read_check(REG_CAM1_RESP, mmio_word_t'(r1));
        read_check(REG_CAM1_RESP_CNT, resp_total[1]);
        // Both ports idle with full credits
        read_check(REG_CAM_STATUS, 32'h0000_0202);
    endtask

    task automatic queue_overflow();
        int base0;
        base0 = sent0.size();
        for (int k = 0; k < 2; k++) reg_write(REG_CAM0_CMD, 32'hE000_0000 + k, 4'hF);
        wait_sent(0, base0 + 2);
        for (int k = 0; k < DEPTH + 2; k++) reg_write(REG_CAM0_CMD, 32'hE100_0000 + k, 4'hF);
        idle_cycles(4);
        check_word("cam0 commands with no credit", base0 + 2, sent0.size());
        // cam0 byte has overflow set, fill 4, no credits
        read_check(REG_CAM_STATUS, 32'h0000_02C0);
        for (int k = 0; k < DEPTH; k++) begin
            send_resp(0, cam_resp_t'(32'h3C000 + k));
            wait_sent(0, base0 + 3 + k);
        end
        for (int k = 0; k < 2; k++) send_resp(0, cam_resp_t'(32'h3D000 + k));
        idle_cycles(4);
        check_word("cam0 commands after drain", base0 + 2 + DEPTH, sent0.size());
        for (int k = 0; k < 2; k++)
            check_cmd($sformatf("cam0_cmd %0d", base0 + k), 32'hE000_0000 + k, sent0[base0 + k]);
        for (int k = 0; k < DEPTH; k++)
            check_cmd($sformatf("cam0_cmd %0d", base0 + 2 + k), 32'hE100_0000 + k,
                      sent0[base0 + 2 + k]);
        read_check(REG_CAM_STATUS, 32'h0000_0282);
        read_check(REG_CAM0_RESP_CNT, resp_total[0]);
    endtask

    task automatic irq_flow();
        int n;
        int count;
        reg_write(REG_IRQ_STAT, 32'h3, 4'hF);
        read_check(REG_IRQ_STAT, 32'h0);
        reg_write(REG_IRQ_EN, 32'h2, 4'hF);
        read_check(REG_IRQ_EN, 32'h2);
        check_word("irq", 32'h0, mmio_word_t'(irq));
        count = sent1.size();
        reg_write(REG_CAM1_CMD, 32'hF100_0001, 4'hF);
        wait_sent(1, count + 1);
        send_resp(1, 18'h0_1234);
        n = 0;
        while (!irq) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) stop_run("irq never rose after a camera 1 response");
        end
        read_check(REG_IRQ_STAT, 32'h2);
        reg_write(REG_IRQ_STAT, 32'h2, 4'hF);
        check_word("irq", 32'h0, mmio_word_t'(irq));
        read_check(REG_IRQ_STAT, 32'h0);
        // Camera 0 is masked
        count = sent0.size();
        reg_write(REG_CAM0_CMD, 32'hF000_0001, 4'hF);
        wait_sent(0, count + 1);
        send_resp(0, 18'h0_4321);
        check_word("irq", 32'h0, mmio_word_t'(irq));
        read_check(REG_IRQ_STAT, 32'h1);
        check_word("irq", 32'h0, mmio_word_t'(irq));
    endtask

    initial begin
        int n;
        araddr          = '0;
        arvalid         = 1'b0;
        rready          = 1'b0;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wstrb           = '0;
        wvalid          = 1'b0;
        bready          = 1'b0;
        cam0_resp       = '0;
        cam0_resp_valid = 1'b0;
        cam1_resp       = '0;
        cam1_resp_valid = 1'b0;
        cmd_pulses      = 0;
        resp_total[0]   = 0;
        resp_total[1]   = 0;
        next_cycle();
        n = 0;
        while (!rst_n) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) stop_run("reset was never released");
        end
        check_word("arready,awready,rvalid,wready,bvalid,cam0/1_cmd_valid,irq,mmio_cmd_valid",
                   32'h180, {23'd0, arready, awready, rvalid, wready, bvalid,
                             cam0_cmd_valid, cam1_cmd_valid, irq, mmio_cmd_valid});
        read_check(REG_CAM_STATUS, 32'h0000_0202);
        read_check(REG_FRAME_BYTES0, 32'h0);
        config_regs();
        bad_addresses();
        command_pulse();
        credit_flow();
        queue_overflow();
        irq_flow();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
hw/mmio_pkg.sv
hw/cam_pkg.sv
hw/mmio_bus_if.sv
hw/mmio_ctrl.sv
hw/mmio_regfile.sv
hw/cam_cmd_port.sv
hw/mmio_top.sv
testbench/tb_clk_gen.sv
testbench/mmio_asserts.sv
testbench/tb_mmio.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mmio
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# The simulator's exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
